/* hdl/fm_pkg.sv */
package fm_pkg;

    // tile geometry
    localparam int DW = 32;                         // word width
    localparam int TM = 8;                          // channels per tile
    localparam int TR = 8;                          // rows per tile
    localparam int TC = 8;                          // columns per tile
    localparam int X  = 4;                          // banks, power of two
    localparam int K  = 3;                          // kernel size, stride 1

    localparam int LC_N       = TM / X;             // local channels per bank
    localparam int OR_N       = TR - K + 1;         // output rows, no padding
    localparam int OC_N       = TC - K + 1;         // output cols
    localparam int BANK_WORDS = LC_N * TR * TC;
    localparam int AW         = $clog2(BANK_WORDS); // bank address width
    localparam int AXW        = AW + 1;             // one spare bit for range checks
    localparam int LOAD_WORDS = TM * TR * TC;       // words in one tile
    localparam int SWEEP_LEN  = LC_N * OR_N * OC_N * K * K;
    localparam int RD_LAT     = 2;                  // addr reg then data reg

    // counter widths
    localparam int XW  = $clog2(X);
    localparam int TMW = $clog2(TM);
    localparam int TRW = $clog2(TR);
    localparam int TCW = $clog2(TC);
    localparam int LCW = (LC_N > 1) ? $clog2(LC_N) : 1;
    localparam int ORW = $clog2(OR_N);
    localparam int OCW = $clog2(OC_N);
    localparam int KW  = $clog2(K);
    localparam int LDW = $clog2(LOAD_WORDS + 1);    // holds the full count
    localparam int SWW = $clog2(SWEEP_LEN);

    // wrap points, sized to match their counters
    localparam logic [TCW-1:0] TC_MAX     = TCW'(TC - 1);
    localparam logic [TRW-1:0] TR_MAX     = TRW'(TR - 1);
    localparam logic [TMW-1:0] TM_MAX     = TMW'(TM - 1);
    localparam logic [LCW-1:0] LC_MAX     = LCW'(LC_N - 1);
    localparam logic [ORW-1:0] OR_MAX     = ORW'(OR_N - 1);
    localparam logic [OCW-1:0] OC_MAX     = OCW'(OC_N - 1);
    localparam logic [KW-1:0]  K_MAX      = KW'(K - 1);
    localparam logic [LDW-1:0] LOAD_FULL  = LDW'(LOAD_WORDS);
    localparam logic [SWW-1:0] SWEEP_LAST = SWW'(SWEEP_LEN - 1);

    // address strides inside a bank
    localparam logic [AXW-1:0] ROW_STRIDE   = AXW'(TC);
    localparam logic [AXW-1:0] PLANE_STRIDE = AXW'(TR * TC);
    localparam logic [AXW-1:0] BANK_LIMIT   = AXW'(BANK_WORDS);

    typedef struct packed {
        logic          restart;                     // load_start, one cycle late
        logic [XW-1:0] bank;                        // target bank, channel mod X
        logic          strobe;
        logic [DW-1:0] data;
    } fm_wr_t;

    typedef struct packed {
        logic [AW-1:0] addr;
        logic          valid;
        logic          last;                        // final step of the sweep
    } fm_rd_t;

    typedef struct packed {
        logic [X-1:0][DW-1:0] data;                 // word x is channel lc*X+x
        logic                 valid;
        logic                 last;
    } fm_vec_t;

endpackage

/* hdl/fm_load_router.sv */
module fm_load_router (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  load_start,
    input  logic                  wr_ena,
    input  logic [fm_pkg::DW-1:0] wr_data,
    output fm_pkg::fm_wr_t        wr,
    output logic                  load_done
);

    logic [fm_pkg::TCW-1:0] col_cnt;
    logic [fm_pkg::TRW-1:0] row_cnt;
    logic [fm_pkg::TMW-1:0] ch_cnt;
    logic [fm_pkg::LDW-1:0] word_cnt;
    logic [fm_pkg::TCW-1:0] col_cur;
    logic [fm_pkg::TRW-1:0] row_cur;
    logic [fm_pkg::TMW-1:0] ch_cur;
    logic [fm_pkg::LDW-1:0] word_cur;
    logic [fm_pkg::LDW-1:0] word_nxt;
    logic                   col_wrap;
    logic                   row_wrap;
    logic                   restart_q;
    logic                   strobe_q;
    logic                   done_q;
    logic [fm_pkg::XW-1:0]  bank_q;
    logic [fm_pkg::DW-1:0]  data_q;

    // position of the word on the input now
    // load_start rewinds to the tile origin, so a word may share its cycle
    always_comb begin
        col_cur  = load_start ? '0 : col_cnt;
        row_cur  = load_start ? '0 : row_cnt;
        ch_cur   = load_start ? '0 : ch_cnt;
        word_cur = load_start ? '0 : word_cnt;
    end

    assign col_wrap = (col_cur == fm_pkg::TC_MAX);
    assign row_wrap = col_wrap && (row_cur == fm_pkg::TR_MAX); // last word of a channel
    assign word_nxt = word_cur + 1'b1;

    // stream order is channel, row, column
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt  <= '0;
            row_cnt  <= '0;
            ch_cnt   <= '0;
            word_cnt <= '0;
        end else if (wr_ena) begin
            col_cnt  <= col_wrap ? '0 : col_cur + 1'b1;
            row_cnt  <= row_wrap ? '0 : (col_wrap ? row_cur + 1'b1 : row_cur);
            if (row_wrap) begin
                ch_cnt <= (ch_cur == fm_pkg::TM_MAX) ? '0 : ch_cur + 1'b1;
            end else begin
                ch_cnt <= ch_cur;
            end
            word_cnt <= word_nxt;                  // words taken since load_start
        end else if (load_start) begin
            col_cnt  <= '0;
            row_cnt  <= '0;
            ch_cnt   <= '0;
            word_cnt <= '0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            restart_q <= 1'b0;
            strobe_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            restart_q <= load_start;               // banks rewind with the router
            strobe_q  <= wr_ena;
            done_q    <= wr_ena && (word_nxt == fm_pkg::LOAD_FULL);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_ena) begin
            bank_q <= ch_cur[fm_pkg::XW-1:0];      // channel mod X
            data_q <= wr_data;
        end
    end

    assign wr.restart = restart_q;
    assign wr.bank    = bank_q;
    assign wr.strobe  = strobe_q;
    assign wr.data    = data_q;
    assign load_done  = done_q;                    // same cycle as the last word's wr

    // a full tile takes no more words until the next load_start
    a_no_word_after_tile: assert property (@(posedge clk) disable iff (!rst_n)
        (word_cnt == fm_pkg::LOAD_FULL) && !load_start |-> !wr_ena);

endmodule

/* hdl/input_fm_bank.sv */
module input_fm_bank #(
    parameter int unsigned BANK_ID = 0              // any index below X
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fm_pkg::fm_wr_t        wr,
    input  fm_pkg::fm_rd_t        rd,
    output logic [fm_pkg::DW-1:0] rd_data
);

    // simple dual-port storage, one write port and one read port
    logic [fm_pkg::DW-1:0]  mem [fm_pkg::BANK_WORDS];

    logic                   wr_sel_q;              // registered write for this bank
    logic [fm_pkg::DW-1:0]  wr_data_q;
    logic [fm_pkg::AXW-1:0] wr_cnt;                // spare top bit flags a full bank
    logic [fm_pkg::AW-1:0]  rd_addr_q;
    logic                   bank_hit;

    // every bank sees the same write, keep only our channels
    assign bank_hit = wr.strobe && (wr.bank == BANK_ID[fm_pkg::XW-1:0]);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_sel_q <= 1'b0;
        end else begin
            wr_sel_q <= bank_hit;
        end
    end

    always_ff @(posedge clk) begin
        wr_data_q <= wr.data;
    end

    // words arrive in ascending address order
    // so the write address is just a running count
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_cnt <= '0;
        end else if (wr.restart) begin
            wr_cnt <= '0;                          // new tile starts at local address 0
        end else if (wr_sel_q) begin
            wr_cnt <= wr_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_sel_q) begin
            mem[wr_cnt[fm_pkg::AW-1:0]] <= wr_data_q;
        end
    end

    // read side
    // address reg then output reg, two cycles from rd.addr to rd_data
    always_ff @(posedge clk) begin
        if (rd.valid) begin
            rd_addr_q <= rd.addr;                  // hold last addr when idle
        end
        rd_data <= mem[rd_addr_q];
    end

    // router must never hand a bank more than its share of the tile
    a_bank_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        wr_sel_q |-> (wr_cnt < fm_pkg::BANK_LIMIT));

endmodule

/* hdl/fm_window_addr_gen.sv */
module fm_window_addr_gen (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           rd_start,
    output fm_pkg::fm_rd_t rd,
    output logic           rd_busy
);

    // loop nest, outer to inner
    logic [fm_pkg::LCW-1:0] lc;                    // local channel
    logic [fm_pkg::ORW-1:0] orow;                  // output row
    logic [fm_pkg::OCW-1:0] ocol;                  // output col
    logic [fm_pkg::KW-1:0]  kr;                    // kernel row
    logic [fm_pkg::KW-1:0]  kc;                    // kernel col

    logic [fm_pkg::SWW-1:0] step;                  // flat step index
    logic                   busy;
    logic                   kc_wrap;
    logic                   kr_wrap;
    logic                   ocol_wrap;
    logic                   orow_wrap;
    logic                   lc_wrap;
    logic                   last_step;

    logic [fm_pkg::AXW-1:0] row_pos;
    logic [fm_pkg::AXW-1:0] col_pos;
    logic [fm_pkg::AXW-1:0] ch_base;
    logic [fm_pkg::AXW-1:0] addr_full;

    // carry chain, each level wraps only when all inner levels wrap
    assign kc_wrap   = (kc == fm_pkg::K_MAX);
    assign kr_wrap   = kc_wrap && (kr == fm_pkg::K_MAX);
    assign ocol_wrap = kr_wrap && (ocol == fm_pkg::OC_MAX);
    assign orow_wrap = ocol_wrap && (orow == fm_pkg::OR_MAX);
    assign lc_wrap   = orow_wrap && (lc == fm_pkg::LC_MAX);

    assign last_step = (step == fm_pkg::SWEEP_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy <= 1'b0;
            step <= '0;
            lc   <= '0;
            orow <= '0;
            ocol <= '0;
            kr   <= '0;
            kc   <= '0;
        end else if (!busy) begin
            busy <= rd_start;                      // counters already sit at zero
        end else begin
            kc <= kc_wrap ? '0 : kc + 1'b1;
            if (kc_wrap) begin
                kr <= kr_wrap ? '0 : kr + 1'b1;
            end
            if (kr_wrap) begin
                ocol <= ocol_wrap ? '0 : ocol + 1'b1;
            end
            if (ocol_wrap) begin
                orow <= orow_wrap ? '0 : orow + 1'b1;
            end
            if (orow_wrap) begin
                lc <= lc_wrap ? '0 : lc + 1'b1;
            end
            step <= last_step ? '0 : step + 1'b1;
            if (last_step) begin
                busy <= 1'b0;                      // rd_start ignored until here
            end
        end
    end

    // addr = lc*TR*TC + (orow+kr)*TC + (ocol+kc)
    always_comb begin
        row_pos = {{(fm_pkg::AXW - fm_pkg::ORW){1'b0}}, orow}
                + {{(fm_pkg::AXW - fm_pkg::KW){1'b0}}, kr};
        col_pos = {{(fm_pkg::AXW - fm_pkg::OCW){1'b0}}, ocol}
                + {{(fm_pkg::AXW - fm_pkg::KW){1'b0}}, kc};
        ch_base = {{(fm_pkg::AXW - fm_pkg::LCW){1'b0}}, lc} * fm_pkg::PLANE_STRIDE;
        addr_full = ch_base + row_pos * fm_pkg::ROW_STRIDE + col_pos;
    end

    assign rd.addr  = addr_full[fm_pkg::AW-1:0];
    assign rd.valid = busy;
    assign rd.last  = busy && last_step;
    assign rd_busy  = busy;

    // window never leaves the bank
    a_addr_in_bank: assert property (@(posedge clk) disable iff (!rst_n)
        rd.valid |-> (addr_full < fm_pkg::BANK_LIMIT));

    // flat count and loop nest agree on where the sweep ends
    a_last_on_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        rd.valid |-> (rd.last == lc_wrap));

endmodule

/* hdl/fm_read_align.sv */
module fm_read_align (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  fm_pkg::fm_rd_t                       rd,
    input  logic [fm_pkg::X-1:0][fm_pkg::DW-1:0] bank_data,
    output fm_pkg::fm_vec_t                      out
);

    // marks travel beside the bank pipeline
    // stage 0 lines up with the address reg, stage 1 with the data reg
    logic [fm_pkg::RD_LAT-1:0] vld_sr;
    logic [fm_pkg::RD_LAT-1:0] lst_sr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_sr <= '0;
            lst_sr <= '0;
        end else begin
            vld_sr <= {vld_sr[fm_pkg::RD_LAT-2:0], rd.valid};
            lst_sr <= {lst_sr[fm_pkg::RD_LAT-2:0], rd.last};
        end
    end

    // bank outputs are already registered
    assign out.data  = bank_data;                  // lane x is bank x
    assign out.valid = vld_sr[fm_pkg::RD_LAT-1];
    assign out.last  = lst_sr[fm_pkg::RD_LAT-1];

    // last only ever rides on a real vector
    a_last_has_valid: assert property (@(posedge clk) disable iff (!rst_n)
        out.last |-> out.valid);

endmodule

/* hdl/in_fm_buffer.sv */
module in_fm_buffer (
    input  logic                  clk,
    input  logic                  rst_n,
    // load side
    input  logic                  load_start,
    input  logic                  wr_ena,
    input  logic [fm_pkg::DW-1:0] wr_data,
    output logic                  load_done,
    // compute side
    input  logic                  rd_start,
    output logic                  rd_busy,
    output fm_pkg::fm_vec_t       out
);

    fm_pkg::fm_wr_t                       wr;          // shared by all banks
    fm_pkg::fm_rd_t                       rd;          // same addr to all banks
    logic [fm_pkg::X-1:0][fm_pkg::DW-1:0] bank_data;

    // stream in, steer to banks
    fm_load_router u_router (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_start (load_start),
        .wr_ena     (wr_ena),
        .wr_data    (wr_data),
        .wr         (wr),
        .load_done  (load_done)
    );

    // bank b holds channels b, b+X, b+2X and so on
    for (genvar b = 0; b < fm_pkg::X; b++) begin : g_bank
        input_fm_bank #(
            .BANK_ID (b)
        ) u_bank (
            .clk     (clk),
            .rst_n   (rst_n),
            .wr      (wr),
            .rd      (rd),
            .rd_data (bank_data[b])
        );
    end

    // 3x3 window walk
    fm_window_addr_gen u_addr_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .rd_start (rd_start),
        .rd       (rd),
        .rd_busy  (rd_busy)
    );

    // marks delayed to meet the data
    fm_read_align u_align (
        .clk       (clk),
        .rst_n     (rst_n),
        .rd        (rd),
        .bank_data (bank_data),
        .out       (out)
    );

endmodule

/* dv/tb_clk_gen.sv */
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;                    // period 100
    end

    // reset held for 10 cycles, released away from the rising edge
    initial begin
        rst_n = 1'b0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

/* dv/tb_in_fm_buffer.sv */
module tb_in_fm_buffer;

    localparam logic [31:0] SEED = 32'hd70b63d3;
    // two loads at up to 2 cycles a word, a short aborted load, two sweeps and margin
    localparam int MAX_CYCLES = 4000;

    typedef logic [fm_pkg::X-1:0][fm_pkg::DW-1:0] lane_vec_t;

    logic                  clk;
    logic                  rst_n;
    logic                  load_start;
    logic                  wr_ena;
    logic [fm_pkg::DW-1:0] wr_data;
    logic                  rd_start;
    logic                  load_done;
    logic                  rd_busy;
    fm_pkg::fm_vec_t       out_vec;

    logic [fm_pkg::DW-1:0] tile [fm_pkg::TM][fm_pkg::TR][fm_pkg::TC]; // channel, row, col

    int err_cnt   = 0;
    int test_cnt  = 0;
    int pass_cnt  = 0;
    int cycle_cnt = 0;
    int acc_words = 0;                             // accepted since load_start
    int done_cnt  = 0;                             // load_done pulses this load
    int vec_cnt   = 0;                             // valid vectors this sweep
    int last_cnt  = 0;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    in_fm_buffer u_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .load_start (load_start),
        .wr_ena     (wr_ena),
        .wr_data    (wr_data),
        .load_done  (load_done),
        .rd_start   (rd_start),
        .rd_busy    (rd_busy),
        .out        (out_vec)
    );

    // expected lanes for one sweep step
    // step order is lc, orow, ocol, kr, kc with kc fastest
    function automatic lane_vec_t ref_window(input int step);
        int t;
        int kc;
        int kr;
        int ocol;
        int orow;
        int lc;
        lane_vec_t v;
        t    = step;
        kc   = t % fm_pkg::K;
        t    = t / fm_pkg::K;
        kr   = t % fm_pkg::K;
        t    = t / fm_pkg::K;
        ocol = t % fm_pkg::OC_N;
        t    = t / fm_pkg::OC_N;
        orow = t % fm_pkg::OR_N;
        lc   = t / fm_pkg::OR_N;
        for (int x = 0; x < fm_pkg::X; x++) begin
            v[x] = tile[lc * fm_pkg::X + x][orow + kr][ocol + kc]; // lane x is channel lc*X+x
        end
        return v;
    endfunction

    // input side bookkeeping, inputs are stable at the rising edge
    always @(posedge clk) begin
        if (rst_n) begin
            cycle_cnt = cycle_cnt + 1;
            if (load_start) begin
                acc_words = 0;
            end else if (wr_ena) begin
                acc_words = acc_words + 1;
            end
        end
    end

    initial begin
        wait (cycle_cnt >= MAX_CYCLES);
        $display("ERROR t=%0t: run did not finish within %0d cycles", $time, MAX_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    // comparator, outputs are registered so mid-cycle sampling is safe
    always @(negedge clk) begin : compare
        lane_vec_t exp_data;
        logic      exp_last;
        if (rst_n) begin
            if (load_done) begin
                done_cnt = done_cnt + 1;
                if (acc_words != fm_pkg::LOAD_WORDS) begin
                    $display("ERROR t=%0t: load_done raised after only %0d of %0d words",
                             $time, acc_words, fm_pkg::LOAD_WORDS);
                    err_cnt++;
                end
            end
            if (out_vec.valid) begin
                if (vec_cnt >= fm_pkg::SWEEP_LEN) begin
                    $display("ERROR t=%0t: out.valid seen after the final vector of the sweep",
                             $time);
                    err_cnt++;
                end else begin
                    exp_data = ref_window(vec_cnt);
                    exp_last = (vec_cnt == fm_pkg::SWEEP_LEN - 1);
                    for (int x = 0; x < fm_pkg::X; x++) begin
                        if (out_vec.data[x] !== exp_data[x]) begin
                            $display("MISMATCH t=%0t out.data[%0d] step %0d: got %h expected %h",
                                     $time, x, vec_cnt, out_vec.data[x], exp_data[x]);
                            err_cnt++;
                        end
                    end
                    if (out_vec.last !== exp_last) begin
                        $display("MISMATCH t=%0t out.last step %0d: got %b expected %b",
                                 $time, vec_cnt, out_vec.last, exp_last);
                        err_cnt++;
                    end
                end
                vec_cnt = vec_cnt + 1;
            end
            if (out_vec.last) begin
                last_cnt = last_cnt + 1;
            end
        end
    end

    task automatic check_low(input string name, input logic got);
        if (got !== 1'b0) begin
            $display("MISMATCH t=%0t %s: got %b expected 0", $time, name, got);
            err_cnt++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int expected);
        if (got != expected) begin
            $display("MISMATCH t=%0t %s: got %0d expected %0d", $time, name, got, expected);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        test_cnt++;
        if (err_cnt == errs_before) begin
            pass_cnt++;
            $display("test %0d %s: ok", test_cnt, name);
        end else begin
            $display("test %0d %s: %0d errors", test_cnt, name, err_cnt - errs_before);
        end
    endtask

    task automatic fill_tile();
        for (int c = 0; c < fm_pkg::TM; c++) begin
            for (int r = 0; r < fm_pkg::TR; r++) begin
                for (int col = 0; col < fm_pkg::TC; col++) begin
                    tile[c][r][col] = $urandom();
                end
            end
        end
    endtask

    // a load cut short by the next load_start, its words must not survive
    task automatic stream_partial(input int n_words);
        load_start = 1'b1;
        @(negedge clk);
        load_start = 1'b0;
        repeat (n_words) begin
            wr_ena  = 1'b1;
            wr_data = $urandom();                  // junk, not part of any tile
            @(negedge clk);
        end
        wr_ena = 1'b0;
    endtask

    // load_start on its own, then the tile in channel, row, column order
    task automatic stream_tile();
        int gap;
        done_cnt   = 0;
        load_start = 1'b1;
        @(negedge clk);
        load_start = 1'b0;
        for (int c = 0; c < fm_pkg::TM; c++) begin
            for (int r = 0; r < fm_pkg::TR; r++) begin
                for (int col = 0; col < fm_pkg::TC; col++) begin
                    gap = $urandom_range(1);       // 0 or 1 idle cycles
                    repeat (gap) begin
                        wr_ena = 1'b0;
                        @(negedge clk);
                    end
                    wr_ena  = 1'b1;
                    wr_data = tile[c][r][col];
                    @(negedge clk);
                end
            end
        end
        wr_ena = 1'b0;
        while (done_cnt == 0) begin
            @(negedge clk);
        end
        repeat (4) @(negedge clk);                 // room for a stray second pulse
        check_count("load_done pulses", done_cnt, 1);
    endtask

    // one sweep, optionally with a second rd_start while busy
    task automatic sweep(input bit poke_busy);
        vec_cnt  = 0;
        last_cnt = 0;
        rd_start = 1'b1;
        @(negedge clk);
        rd_start = 1'b0;
        if (poke_busy) begin
            repeat (5) @(negedge clk);
            if (rd_busy !== 1'b1) begin
                $display("MISMATCH t=%0t rd_busy: got %b expected 1", $time, rd_busy);
                err_cnt++;
            end
            rd_start = 1'b1;                       // must be ignored
            @(negedge clk);
            rd_start = 1'b0;
        end
        while (last_cnt == 0) begin
            @(negedge clk);
        end
        repeat (6) @(negedge clk);
    endtask

    initial begin
        int errs;
        load_start = 1'b0;
        wr_ena     = 1'b0;
        wr_data    = '0;
        rd_start   = 1'b0;
        void'($urandom(SEED));
        wait (rst_n);

        errs = err_cnt;
        repeat (4) begin
            @(negedge clk);
            check_low("load_done", load_done);
            check_low("rd_busy", rd_busy);
            check_low("out.valid", out_vec.valid);
            check_low("out.last", out_vec.last);
        end
        finish_test("idle after reset", errs);

        errs = err_cnt;
        fill_tile();
        stream_tile();
        finish_test("first load", errs);

        errs = err_cnt;
        sweep(1'b1);
        check_count("valid vectors", vec_cnt, fm_pkg::SWEEP_LEN);
        finish_test("first sweep data", errs);

        errs = err_cnt;
        check_count("out.last pulses", last_cnt, 1);
        check_low("rd_busy", rd_busy);
        repeat (10) @(negedge clk);                // a restarted sweep would show up here
        check_count("valid vectors", vec_cnt, fm_pkg::SWEEP_LEN);
        check_low("rd_busy", rd_busy);
        finish_test("last mark and busy start", errs);

        errs = err_cnt;
        fill_tile();
        stream_partial(37);                        // bank 0 left part way through its count
        stream_tile();
        sweep(1'b0);
        check_count("valid vectors", vec_cnt, fm_pkg::SWEEP_LEN);
        check_count("out.last pulses", last_cnt, 1);
        finish_test("reload and sweep", errs);

        $display("summary: %0d tests, %0d ok, %0d errors", test_cnt, pass_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* in_fm_buffer.f */
hdl/fm_pkg.sv
hdl/fm_load_router.sv
hdl/input_fm_bank.sv
hdl/fm_window_addr_gen.sv
hdl/fm_read_align.sv
hdl/in_fm_buffer.sv
dv/tb_clk_gen.sv
dv/tb_in_fm_buffer.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_in_fm_buffer \
    -f in_fm_buffer.f \
    -o sim_in_fm_buffer

out=$(./obj_dir/sim_in_fm_buffer)
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** PASSED ***'
